// File: verilog.f
+incdir+sim
hdl/cpuPkg.sv
hdl/cpuBusIf.sv
hdl/seqCtrl.sv
hdl/regFile.sv
hdl/memAccess.sv
hdl/execUnit.sv
hdl/pcUnit.sv
hdl/cpuTop.sv
sim/tbCpu.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbCpu -f verilog.f -o simCpu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simCpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: sim/tbModel.svh
// Instruction-level reference model on its own copy of the RAM
word_t modelMem  [MemWords];
word_t modelRegs [RegCount];
word_t modelIp;

function automatic int unsigned wordIdx(word_t addr);
  return {22'd0, addr[11:2]}; // Wraps inside the 4 KB RAM
endfunction

// Executes the instruction at modelIp and reports what the core should show
task automatic modelStep(output opCode_e op, output logic wrEn, output word_t wrAddr,
                         output word_t wrData, output word_t cycles, output word_t reads,
                         output logic halt);
  instrWord_u iw;
  regIdx_t    a;
  word_t      k, aV, bV, cV, sp, nextIp;
  flags_t     f;
  iw.raw = modelMem[wordIdx(modelIp)];
  k      = modelMem[wordIdx(modelIp + WordBytes)]; // Only used by long forms
  op     = opCode_e'(iw.fields.opCode);
  a      = iw.fields.regA[3:0];
  aV     = modelRegs[a];
  bV     = modelRegs[iw.fields.regB[3:0]];
  cV     = modelRegs[iw.fields.regC[3:0]];
  sp     = modelRegs[SpReg];
  f      = flags_t'(modelRegs[FlagsReg][2:0]);
  wrEn   = 1'b0;
  wrAddr = '0;
  wrData = '0;
  halt   = (op == JmpC) && (k == modelIp); // Jump to itself ends the program
  cycles = 32'd5 + (op[7] ? 32'd2 : 32'd0) + (op[6] ? 32'd3 : 32'd0);
  reads  = op[7] ? 32'd2 : 32'd1; // Instruction word and constant
  nextIp = modelIp + (op[7] ? 32'd8 : 32'd4);
  case (op)
    MovRC:  modelRegs[a] = k;
    MovRR:  modelRegs[a] = bV;
    MovRdC: begin
      modelRegs[a] = modelMem[wordIdx(k)];
      reads++;
    end
    MovRdR: begin
      modelRegs[a] = modelMem[wordIdx(bV)];
      reads++;
    end
    AddRRR: modelRegs[a] = bV + cV;
    AddRRC: modelRegs[a] = bV + k;
    SubRRR: modelRegs[a] = bV - cV;
    SubRRC: modelRegs[a] = bV - k;
    IncR:   modelRegs[a] = aV + 32'd1;
    DecR:   modelRegs[a] = aV - 32'd1;
    ShlRRR: modelRegs[a] = bV << cV; // Zero once shift reaches 32
    ShrRRR: modelRegs[a] = bV >> cV;
    NegRR:  modelRegs[a] = 32'd0 - bV;
    CmpRR:  modelRegs[FlagsReg] = {29'd0, aV > bV, aV < bV, aV == bV}; // gt lt eq
    CmpRC:  modelRegs[FlagsReg] = {29'd0, aV > k, aV < k, aV == k};
    MovdCR: begin
      wrEn   = 1'b1;
      wrAddr = k;
      wrData = bV;
    end
    PushR, CallR: begin // Stack grows upward and SP names the free slot
      wrEn   = 1'b1;
      wrAddr = sp;
      wrData = (op == CallR) ? modelIp : aV;
      modelRegs[SpReg] = sp + 32'd4;
      if (op == CallR) nextIp = aV;
    end
    PopR: begin
      modelRegs[a]     = modelMem[wordIdx(sp - 32'd4)];
      modelRegs[SpReg] = sp - 32'd4; // SP update wins over regA
      reads++;
    end
    Ret: begin
      nextIp           = modelMem[wordIdx(sp - 32'd4)] + 32'd4; // Past the call
      modelRegs[SpReg] = sp - 32'd4;
      reads++;
    end
    JmpC:  nextIp = k;
    JeC:   if (f.eq) nextIp = k;
    JneC:  if (!f.eq) nextIp = k;
    JzRC:  if (aV == '0) nextIp = k;
    JnzRC: if (aV != '0) nextIp = k;
    default: failNow("Reference model reached a word that is not a known opcode");
  endcase
  if (wrEn) modelMem[wordIdx(wrAddr)] = wrData;
  modelIp = nextIp;
endtask

task automatic checkWord(string testName, word_t expVal, word_t actVal);
  if (actVal !== expVal) begin
    $display("ERROR %s: expected %h, actual %h", testName, expVal, actVal);
    failNow("Word value mismatch");
  end
endtask

task automatic checkOp(string testName, opCode_e expVal, opCode_e actVal);
  if (actVal !== expVal) begin
    $display("ERROR %s: expected %s (%h), actual %s (%h)", testName,
             expVal.name(), expVal, actVal.name(), actVal);
    failNow("Opcode mismatch");
  end
endtask

// File: sim/tbCpu.sv
module tbCpu;
  import cpuPkg::*;

  localparam int    MemWords    = 1024;     // 4 KB RAM
  localparam int    ProgLen     = 40;
  localparam int    MaxCycles   = 10;       // Long form with memory access
  localparam int    ResetCycles = 8;
  localparam word_t SubBase     = 32'h400;  // Subroutines live here
  localparam word_t DataBase    = 32'h800;
  localparam int    DataWords   = 64;
  localparam word_t StackBase   = 32'hC00;

  logic    clk;
  logic    rstN;
  word_t   ramIn;
  word_t   ramAddress, ramOut, ipointer;
  logic    readReq, writeReq, retire;
  opCode_e opCode;

  word_t ram [MemWords];     // RAM seen by the DUT
  word_t lfsr       = 32'd96;
  int    instrCount = 0;     // Instructions placed in RAM
  logic  progReady  = 1'b0;

  cpuTop #(.ResetAddr(32'h0)) i_dut (
    .clk(clk), .rstN(rstN), .ramIn(ramIn), .ramAddress(ramAddress), .ramOut(ramOut),
    .readReq(readReq), .writeReq(writeReq), .retire(retire), .ipointer(ipointer),
    .opCode(opCode)
  );

  task automatic failNow(string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped");
  endtask

`include "tbModel.svh"

  // Galois LFSR stepped once per bit
  function automatic word_t takeBits(int n);
    word_t v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Destinations keep clear of SP and flags with a random high nibble
  function automatic logic [7:0] regField(logic anyReg);
    if (anyReg) return 8'(takeBits(8));
    return {4'(takeBits(4)), 4'(32'd2 + takeBits(4) % 32'd14)};
  endfunction

  function automatic word_t dataAddr();
    return DataBase + (takeBits(6) << 2);
  endfunction

  task automatic putInstr(inout word_t pc, input opCode_e op, input logic [7:0] a, b, c);
    ram[wordIdx(pc)] = {c, b, a, 8'(op)};
    pc += WordBytes;
    instrCount++;
  endtask

  task automatic putConst(inout word_t pc, input word_t k);
    ram[wordIdx(pc)] = k;
    pc += WordBytes;
  endtask

  task automatic emitAlu(inout word_t pc);
    logic [7:0] d, b, c;
    d = regField(1'b0);
    b = regField(1'b1);
    c = regField(1'b1);
    case (takeBits(4))
      0: putInstr(pc, MovRR, d, b, c);
      1: putInstr(pc, AddRRR, d, b, c);
      2: putInstr(pc, SubRRR, d, b, c);
      3: putInstr(pc, IncR, d, b, c);
      4: putInstr(pc, DecR, d, b, c);
      5: putInstr(pc, ShlRRR, d, b, c);
      6: putInstr(pc, ShrRRR, d, b, c);
      7: putInstr(pc, NegRR, d, b, c);
      8: begin
        putInstr(pc, AddRRC, d, b, c);
        putConst(pc, takeBits(32));
      end
      9: begin
        putInstr(pc, SubRRC, d, b, c);
        putConst(pc, takeBits(32));
      end
      default: begin
        putInstr(pc, MovRC, d, b, c);
        putConst(pc, takeBits(32));
      end
    endcase
  endtask

  // Jump over one instruction whether taken or not
  task automatic jumpOver(inout word_t pc, input opCode_e op, input logic [7:0] a);
    word_t slot;
    putInstr(pc, op, a, regField(1'b1), regField(1'b1));
    slot = pc;
    putConst(pc, '0);
    emitAlu(pc);
    ram[wordIdx(slot)] = pc; // Patch target
  endtask

  task automatic buildProgram();
    word_t      pc    = '0;
    word_t      subPc = SubBase;
    int         depth = 0;      // Words pushed by the program
    logic [7:0] r;
    for (int i = 0; i < MemWords; i++) begin
      ram[i] = (word_t'(i) * 32'h9E3779B1) ^ 32'h5A5A0000; // Unique per address
    end
    for (int i = 0; i < DataWords; i++) begin
      ram[wordIdx(DataBase) + i] = takeBits(32);
    end
    putInstr(pc, MovRC, 8'(SpReg), 8'h00, 8'h00);
    putConst(pc, StackBase);
    while (instrCount < ProgLen) begin
      case (takeBits(3))
        0, 1: emitAlu(pc);
        2: if (takeBits(1) == 1) begin
          putInstr(pc, MovRdC, regField(1'b0), 8'h00, 8'h00);
          putConst(pc, dataAddr());
        end else begin
          r = regField(1'b0); // Pointer register for the indirect load
          putInstr(pc, MovRC, r, 8'h00, 8'h00);
          putConst(pc, dataAddr());
          putInstr(pc, MovRdR, regField(1'b0), r, 8'h00);
        end
        3: begin
          putInstr(pc, MovdCR, regField(1'b1), regField(1'b1), 8'h00);
          putConst(pc, dataAddr());
        end
        4: if (depth > 0 && (depth >= 16 || takeBits(1) == 1)) begin
          putInstr(pc, PopR, regField(1'b0), 8'h00, 8'h00);
          depth--;
        end else begin
          putInstr(pc, PushR, regField(1'b1), 8'h00, 8'h00);
          depth++;
        end
        5: begin
          r = regField(1'b1);
          if (takeBits(1) == 1) begin
            putInstr(pc, CmpRR, r, (takeBits(1) == 1) ? r : regField(1'b1), 8'h00);
          end else begin
            putInstr(pc, CmpRC, r, 8'h00, 8'h00);
            putConst(pc, takeBits(32));
          end
          jumpOver(pc, (takeBits(1) == 1) ? JeC : JneC, 8'h00);
        end
        6: case (takeBits(2))
          0: jumpOver(pc, JmpC, 8'h00);
          2: jumpOver(pc, JnzRC, regField(1'b1));
          default: jumpOver(pc, JzRC, regField(1'b1)); // Many registers still zero
        endcase
        default: begin
          r = regField(1'b0);
          putInstr(pc, MovRC, r, 8'h00, 8'h00);
          putConst(pc, subPc);
          putInstr(pc, CallR, r, 8'h00, 8'h00);
          emitAlu(subPc);
          emitAlu(subPc);
          putInstr(subPc, Ret, 8'h00, 8'h00, 8'h00);
        end
      endcase
    end
    putInstr(pc, JmpC, 8'h00, 8'h00, 8'h00);
    putConst(pc, pc - WordBytes); // Spin on itself
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Watchdog sized from the generated program
  initial begin
    wait (progReady);
    repeat (ResetCycles + (instrCount + 1) * MaxCycles * 2) @(posedge clk);
    failNow("Watchdog expired before the program reached its final jump");
  end

  initial begin
    opCode_e expOp;
    logic    expWr, halt, checkNext, wrSeen, rdNow, wrNow, pendRd;
    word_t   expAddr, expData, expCycles, instIp, addrNow, dataNow, pendAddr;
    word_t   expReads, rdCount;
    int      cycle, lastRetire;
    rstN       = 1'b0;
    ramIn      = '0;
    checkNext  = 1'b0;
    wrSeen     = 1'b0;
    rdCount    = '0;
    pendRd     = 1'b0;
    pendAddr   = '0;
    cycle      = 0;
    lastRetire = -1; // No gap check on the first retire
    buildProgram();
    modelMem  = ram;
    modelRegs = '{default: '0};
    modelIp   = '0;
    progReady = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1 rstN = 1'b1;
    instIp = modelIp;
    modelStep(expOp, expWr, expAddr, expData, expCycles, expReads, halt);
    forever begin
      @(negedge clk); // Outputs settled here
      cycle++;
      if (checkNext) begin
        checkWord("next ipointer", modelIp, ipointer);
        checkNext = 1'b0;
        if (halt) break;
        instIp  = modelIp;
        wrSeen  = 1'b0;
        rdCount = '0;
        modelStep(expOp, expWr, expAddr, expData, expCycles, expReads, halt);
      end
      if (readReq) begin
        if (rdCount == '0) checkWord("fetch address", instIp, ramAddress);
        rdCount++;
      end
      if (writeReq) begin
        if (!expWr || wrSeen) failNow("Write request from an instruction that stores nothing");
        checkWord("write address", expAddr, ramAddress);
        checkWord("write data", expData, ramOut);
        wrSeen = 1'b1;
      end
      if (retire) begin
        checkOp("retired opcode", expOp, opCode);
        checkWord("instruction address", instIp, ipointer);
        checkWord("read requests", expReads, rdCount);
        if (lastRetire >= 0) checkWord("retire gap", expCycles, word_t'(cycle - lastRetire));
        if (expWr && !wrSeen) failNow("Store instruction retired without a write request");
        lastRetire = cycle;
        checkNext  = 1'b1;
      end
      rdNow   = readReq;
      wrNow   = writeReq;
      addrNow = ramAddress;
      dataNow = ramOut;
      @(posedge clk); // Request edge
      #1;
      if (pendRd) ramIn = ram[wordIdx(pendAddr)]; // Valid one edge after the request
      pendRd   = rdNow;
      pendAddr = addrNow;
      if (wrNow) ram[wordIdx(addrNow)] = dataNow;
    end
    for (int i = 0; i < DataWords; i++) begin
      checkWord("final data region", modelMem[wordIdx(DataBase) + i],
                ram[wordIdx(DataBase) + i]);
    end
    for (int i = 0; i < 32; i++) begin
      checkWord("final stack region", modelMem[wordIdx(StackBase) + i],
                ram[wordIdx(StackBase) + i]);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: hdl/cpuTop.sv
module cpuTop #(
  parameter cpuPkg::word_t ResetAddr = '0 // First fetch address
) (
  input  logic             clk,
  input  logic             rstN,
  input  cpuPkg::word_t    ramIn,
  output cpuPkg::word_t    ramAddress,
  output cpuPkg::word_t    ramOut,
  output logic             readReq,
  output logic             writeReq,
  output logic             retire,
  output cpuPkg::word_t    ipointer,
  output cpuPkg::opCode_e  opCode
);
  import cpuPkg::*;

  cpuBusIf bus ();

  regIdx_t regA, regB, regC; // Decoded register fields

  seqCtrl uCtrl (
    .clk(clk), .rstN(rstN), .ramIn(ramIn), .bus(bus),
    .regA(regA), .regB(regB), .regC(regC), .retire(retire)
  );

  regFile uRegs (
    .clk(clk), .rstN(rstN), .regA(regA), .regB(regB), .regC(regC), .bus(bus)
  );

  memAccess uMem (
    .clk(clk), .rstN(rstN), .ramIn(ramIn), .ramAddress(ramAddress),
    .ramOut(ramOut), .readReq(readReq), .writeReq(writeReq), .bus(bus)
  );

  execUnit uExec (.bus(bus));

  pcUnit #(.ResetAddr(ResetAddr)) uPc (.clk(clk), .rstN(rstN), .bus(bus));

  assign ipointer = bus.ipointer; // Observed by the testbench
  assign opCode   = bus.opCode;

endmodule

// File: hdl/pcUnit.sv
module pcUnit #(
  parameter cpuPkg::word_t ResetAddr = '0
) (
  input  logic clk,
  input  logic rstN,
  cpuBusIf.pc  bus
);
  import cpuPkg::*;

  word_t nextIp;

  always_comb begin
    if (bus.opCode == JmpC || bus.condJump) begin
      nextIp = bus.constWord;                 // Jump target
    end else if (bus.opCode == CallR) begin
      nextIp = bus.aVal;
    end else if (bus.opCode == Ret) begin
      nextIp = bus.loadValue + WordBytes;     // Skip the call itself
    end else begin
      // Long forms carry a constant word
      nextIp = bus.ipointer + (bus.opCode[7] ? (WordBytes << 1) : WordBytes);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) bus.ipointer <= ResetAddr;
    else if (bus.step == Retire) bus.ipointer <= nextIp;
  end

  aIpAligned: assert property (@(posedge clk) disable iff (!rstN)
    bus.ipointer[1:0] == 2'b00);

endmodule

// File: hdl/execUnit.sv
module execUnit (
  cpuBusIf.exec bus
);
  import cpuPkg::*;

  word_t arithB; // Second arithmetic source
  word_t cmpB;   // Compare partner of aVal

  assign arithB = bus.opCode[7] ? bus.constWord : bus.cVal;
  assign cmpB   = (bus.opCode == CmpRC) ? bus.constWord : bus.bVal;

  always_comb begin
    case (bus.opCode)
      MovRC:                bus.result = bus.constWord;
      MovRdC, MovRdR, PopR: bus.result = bus.loadValue;
      AddRRR, AddRRC:       bus.result = bus.bVal + arithB;
      SubRRR, SubRRC:       bus.result = bus.bVal - arithB;
      IncR:                 bus.result = bus.aVal + 1'b1;
      DecR:                 bus.result = bus.aVal - 1'b1;
      ShlRRR:               bus.result = bus.bVal << bus.cVal;
      ShrRRR:               bus.result = bus.bVal >> bus.cVal; // Logical
      NegRR:                bus.result = -bus.bVal;
      default:              bus.result = bus.bVal; // MovRR
    endcase
  end

  // Unsigned compare
  always_comb begin
    bus.flagsNext.eq = (bus.aVal == cmpB);
    bus.flagsNext.lt = (bus.aVal < cmpB);
    bus.flagsNext.gt = (bus.aVal > cmpB);
  end

endmodule

// File: hdl/memAccess.sv
module memAccess (
  input  logic          clk,
  input  logic          rstN,
  input  cpuPkg::word_t ramIn,
  output cpuPkg::word_t ramAddress,
  output cpuPkg::word_t ramOut,
  output logic          readReq,
  output logic          writeReq,
  cpuBusIf.mem          bus
);
  import cpuPkg::*;

  logic  isLoad;
  logic  isStore;
  word_t dataAddr;

  assign isLoad  = bus.opCode inside {MovRdC, MovRdR, PopR, Ret};
  assign isStore = bus.opCode inside {MovdCR, PushR, CallR};

  always_comb begin
    case (bus.opCode)
      MovRdC, MovdCR: dataAddr = bus.constWord;
      MovRdR:         dataAddr = bus.bVal;
      PopR, Ret:      dataAddr = bus.sp - WordBytes; // Top of stack
      default:        dataAddr = bus.sp;             // Push and call
    endcase
  end

  always_comb begin
    case (bus.opCode)
      PushR:   ramOut = bus.aVal;
      CallR:   ramOut = bus.ipointer; // Return address base
      default: ramOut = bus.bVal;     // MovdCR
    endcase
  end

  // Strobes last exactly one step
  assign readReq = (bus.step == Fetch)
                || (bus.step == RegRead && bus.opCode[7])
                || (bus.step == MemReq && isLoad);
  assign writeReq = (bus.step == MemReq) && isStore;

  always_comb begin
    case (bus.step)
      Fetch:   ramAddress = bus.ipointer;
      RegRead: ramAddress = bus.ipointer + WordBytes; // Constant slot
      default: ramAddress = dataAddr;
    endcase
  end

  // Capture two steps after each request
  always_ff @(posedge clk) begin
    if (bus.step == ConstLoad) bus.constWord <= ramIn;
    if (bus.step == MemDone)   bus.loadValue <= ramIn;
  end

  aOneReq: assert property (@(posedge clk) disable iff (!rstN)
    !(readReq && writeReq));

endmodule

// File: hdl/regFile.sv
module regFile (
  input  logic            clk,
  input  logic            rstN,
  input  cpuPkg::regIdx_t regA,
  input  cpuPkg::regIdx_t regB,
  input  cpuPkg::regIdx_t regC,
  cpuBusIf.regs           bus
);
  import cpuPkg::*;

  word_t regs [RegCount];

  assign bus.sp    = regs[SpReg];
  assign bus.flags = flags_t'(regs[FlagsReg][$bits(flags_t)-1:0]);

  always_ff @(posedge clk) begin
    if (bus.step == RegRead) begin // Operand snapshot
      bus.aVal <= regs[regA];
      bus.bVal <= regs[regB];
      bus.cVal <= regs[regC];
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < RegCount; i++) begin
        regs[i] <= '0;
      end
    end else if (bus.step == Retire) begin
      case (bus.opCode)
        MovRC, MovRR, MovRdC, MovRdR,
        AddRRR, AddRRC, SubRRR, SubRRC,
        IncR, DecR, ShlRRR, ShrRRR, NegRR:
          regs[regA] <= bus.result;
        CmpRR, CmpRC:
          regs[FlagsReg] <= {{(DataWidth-$bits(flags_t)){1'b0}}, bus.flagsNext};
        PushR, CallR:
          regs[SpReg] <= bus.sp + WordBytes; // Stack grows upward
        PopR: begin
          regs[regA]  <= bus.result;         // Loaded word
          regs[SpReg] <= bus.sp - WordBytes; // Pointer wins if regA is SP
        end
        Ret:
          regs[SpReg] <= bus.sp - WordBytes;
        default: ; // Stores and jumps leave the array alone
      endcase
    end
  end

endmodule

// File: hdl/seqCtrl.sv
module seqCtrl (
  input  logic           clk,
  input  logic           rstN,
  input  cpuPkg::word_t  ramIn,  // Instruction word valid in Decode
  cpuBusIf.ctrl          bus,
  output cpuPkg::regIdx_t regA,
  output cpuPkg::regIdx_t regB,
  output cpuPkg::regIdx_t regC,
  output logic           retire
);
  import cpuPkg::*;

  instrWord_u instr;
  step_e      nextStep;
  logic       hasConst;
  logic       hasMem;

  assign instr    = instrWord_u'(ramIn);
  assign hasConst = bus.opCode[7];
  assign hasMem   = bus.opCode[6];

  always_comb begin
    case (bus.step)
      Fetch:     nextStep = FetchWait;
      FetchWait: nextStep = Decode;
      Decode:    nextStep = RegRead;
      RegRead:   nextStep = hasConst ? ConstWait : (hasMem ? MemReq : Retire);
      ConstWait: nextStep = ConstLoad;
      ConstLoad: nextStep = hasMem ? MemReq : Retire;
      MemReq:    nextStep = MemWait;
      MemWait:   nextStep = MemDone;
      MemDone:   nextStep = Retire;
      default:   nextStep = Fetch; // Retire wraps around
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      bus.step   <= Fetch;
      bus.opCode <= opCode_e'(8'h00);
      regA       <= '0;
      regB       <= '0;
      regC       <= '0;
    end else begin
      bus.step <= nextStep; // No stalls
      if (bus.step == Decode) begin
        bus.opCode <= opCode_e'(instr.fields.opCode);
        regA       <= instr.fields.regA[3:0]; // Low bits pick the register
        regB       <= instr.fields.regB[3:0];
        regC       <= instr.fields.regC[3:0];
      end
    end
  end

  // Operands are latched at the end of RegRead
  // and flags only move in Retire, so this is stable when pcUnit samples it
  always_comb begin
    case (bus.opCode)
      JeC:     bus.condJump = bus.flags.eq;
      JneC:    bus.condJump = !bus.flags.eq;
      JzRC:    bus.condJump = (bus.aVal == '0);
      JnzRC:   bus.condJump = (bus.aVal != '0);
      default: bus.condJump = 1'b0;
    endcase
  end

  assign retire = (bus.step == Retire); // One cycle per instruction

  aStepLegal: assert property (@(posedge clk) disable iff (!rstN)
    bus.step inside {[Fetch:Retire]});

endmodule

// File: hdl/cpuBusIf.sv
interface cpuBusIf;
  import cpuPkg::*;

  step_e   step;
  opCode_e opCode;
  logic    condJump;  // Conditional jump taken
  word_t   aVal, bVal, cVal; // Latched operands
  word_t   sp;
  flags_t  flags;
  word_t   constWord; // Word after the instruction
  word_t   loadValue;
  word_t   result;
  flags_t  flagsNext;
  word_t   ipointer;

  modport ctrl (output step, opCode, condJump, input aVal, flags);
  modport regs (input step, opCode, result, flagsNext,
                output aVal, bVal, cVal, sp, flags);
  modport mem  (input step, opCode, ipointer, aVal, bVal, sp,
                output constWord, loadValue);
  modport exec (input opCode, aVal, bVal, cVal, constWord, loadValue,
                output result, flagsNext);
  modport pc   (input step, opCode, condJump, aVal, constWord, loadValue,
                output ipointer);

endinterface

// File: hdl/cpuPkg.sv
package cpuPkg;

  localparam int DataWidth = 32;
  localparam int RegCount  = 16;

  typedef logic [DataWidth-1:0]        word_t;
  typedef logic [$clog2(RegCount)-1:0] regIdx_t;

  localparam regIdx_t SpReg     = 4'd0; // Stack pointer
  localparam regIdx_t FlagsReg  = 4'd1; // Compare flags live here
  localparam word_t   WordBytes = 32'd4; // Short instruction size

  // Bit 7 set: constant word follows
  // Bit 6 set: data memory access
  typedef enum logic [7:0] {
    MovRR  = 8'h01,
    CmpRR  = 8'h02,
    AddRRR = 8'h03,
    SubRRR = 8'h04,
    IncR   = 8'h05,
    DecR   = 8'h06,
    ShlRRR = 8'h07,
    ShrRRR = 8'h08,
    NegRR  = 8'h09,
    MovRdR = 8'h40, // Load through bVal
    PushR  = 8'h41,
    PopR   = 8'h42,
    CallR  = 8'h43,
    Ret    = 8'h44,
    MovRC  = 8'h80,
    JmpC   = 8'h81,
    JeC    = 8'h82,
    JneC   = 8'h83,
    JzRC   = 8'h84,
    JnzRC  = 8'h85,
    CmpRC  = 8'h86,
    AddRRC = 8'h87,
    SubRRC = 8'h88,
    MovRdC = 8'hC0, // Load from constant address
    MovdCR = 8'hC1  // Store to constant address
  } opCode_e;

  typedef enum logic [3:0] {
    Fetch, FetchWait, Decode, RegRead,
    ConstWait, ConstLoad,
    MemReq, MemWait, MemDone,
    Retire
  } step_e;

  typedef struct packed {
    logic [7:0] regC;
    logic [7:0] regB;
    logic [7:0] regA;
    logic [7:0] opCode; // Raw, may hold an unknown code
  } instrFields_t;

  // Constants and load values read raw, instructions by field
  typedef union packed {
    word_t        raw;
    instrFields_t fields;
  } instrWord_u;

  typedef struct packed {
    logic gt;
    logic lt;
    logic eq; // Bit 0
  } flags_t;

endpackage
